// File: source/redmule_cast_pkg.sv
// floating-point format constants and the FP8 source selector, imported by the cast datapath
package redmule_cast_pkg;

  // narrow source format, selected by a level at the cast unit
  typedef enum logic {
    FP8_E5M2 = 1'b0,
    FP8_E4M3 = 1'b1
  } fp8_fmt_e;

  // element widths
  localparam int unsigned Fp8W  = 8;
  localparam int unsigned Fp16W = 16;

  // every NaN leaves the cast unit in this one form
  localparam logic [15:0] Fp16QNaN = 16'h7E00;

  // exponent biases
  // E5M2 shares the FP16 exponent field, so it needs no bias of its own
  localparam int E4m3Bias = 7;
  localparam int Fp16Bias = 15;

endpackage : redmule_cast_pkg

// File: source/redmule_stream_pkg.sv
// default stream geometry for the packer, the word buffer and the cast stage top
package redmule_stream_pkg;

  // word layout
  //   a word is Lanes * Fp16W bits wide
  //   cast mode: FP8 lane i at bits [i*8 +: 8], upper half of the word is zero
  //   bypass mode: FP16 lane i at bits [i*16 +: 16]
  //   the buffer carries one mode bit above the word, 1 = cast

  // elements per word; the top overrides this and passes it down
  localparam int unsigned DefaultLanes = 4;

  // buffer depth in words
  localparam int unsigned DefaultFifoDepth = 4;

endpackage : redmule_stream_pkg

// File: source/redmule_fp8_widen.sv
// combinational widening of one FP8 element (E5M2 or E4M3) to FP16, one instance per lane
`timescale 1ns/100ps

module redmule_fp8_widen import redmule_cast_pkg::*; (
  input  logic [Fp8W-1:0]  elem_i,
  input  fp8_fmt_e         src_fmt_i,
  output logic [Fp16W-1:0] elem_o
);

  // a subnormal with its leading one at bit p lands at FP16 exponent SubBase + p
  localparam int SubBase = Fp16Bias - E4m3Bias - 2;

  logic       sign;
  logic [4:0] e5_exp;
  logic [1:0] e5_man;
  logic [3:0] e4_exp;
  logic [2:0] e4_man;
  logic [4:0] norm_exp;
  logic [4:0] sub_exp;
  logic [2:0] sub_man;

  assign sign   = elem_i[7];
  assign e5_exp = elem_i[6:2];
  assign e5_man = elem_i[1:0];
  assign e4_exp = elem_i[6:3];
  assign e4_man = elem_i[2:0];

  // rebias from 7 to 15
  assign norm_exp = {1'b0, e4_exp} + 5'(Fp16Bias - E4m3Bias);

  // normalize by leading-one position, the hidden one drops out
  always_comb begin
    sub_exp = '0;
    sub_man = '0;
    casez (e4_man)
      3'b1??: begin
        sub_exp = 5'(SubBase + 2);
        sub_man = {e4_man[1:0], 1'b0};
      end
      3'b01?: begin
        sub_exp = 5'(SubBase + 1);
        sub_man = {e4_man[0], 2'b00};
      end
      3'b001: begin
        sub_exp = 5'(SubBase);
        sub_man = 3'b000;
      end
      default: begin
        sub_exp = '0;
        sub_man = '0;
      end
    endcase
  end

  always_comb begin
    if (src_fmt_i == FP8_E5M2) begin
      if (e5_exp == '1 && e5_man != '0) begin
        elem_o = Fp16QNaN;
      end else begin
        elem_o = {elem_i, {(Fp16W - Fp8W){1'b0}}};
      end
    end else if (e4_exp == '1) begin
      elem_o = (e4_man == '0) ? {sign, 5'h1f, 10'h000} : Fp16QNaN;
    end else if (e4_exp != '0) begin
      elem_o = {sign, norm_exp, e4_man, 7'h00};
    end else if (e4_man != '0) begin
      elem_o = {sign, sub_exp, sub_man, 7'h00};
    end else begin
      // signed zero
      elem_o = {sign, 15'h0000};
    end
  end

endmodule : redmule_fp8_widen

// File: source/redmule_castin_packer.sv
// producer side of the cast stage, packs incoming elements into lane words for the buffer
`timescale 1ns/100ps

module redmule_castin_packer import redmule_cast_pkg::*; #(
  parameter int unsigned Lanes = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 clear_i,
  input  logic                 elem_valid_i,
  input  logic [Fp16W-1:0]     elem_i,
  input  logic                 last_i,
  input  logic                 cast_i,
  input  logic                 fifo_full_i,
  output logic                 push_o,
  output logic [Lanes*Fp16W:0] payload_o,
  output logic                 overflow_o
);

  localparam int unsigned WordW = Lanes * Fp16W;
  localparam int unsigned CntW  = (Lanes > 1) ? $clog2(Lanes) : 1;

  logic [CntW-1:0]  cnt_q;
  logic             mode_q;
  logic [WordW-1:0] asm_q;
  logic             pend_q;
  logic [WordW:0]   out_q;
  logic             overflow_q;
  logic             mode_d;
  logic [WordW-1:0] asm_d;
  logic             word_done;

  // mode is taken with the first element, a fresh word starts from zero
  always_comb begin
    mode_d = (cnt_q == '0) ? cast_i : mode_q;
    asm_d  = (cnt_q == '0) ? '0 : asm_q;
    if (mode_d) begin
      asm_d[cnt_q*Fp8W +: Fp8W] = elem_i[Fp8W-1:0];
    end else begin
      asm_d[cnt_q*Fp16W +: Fp16W] = elem_i;
    end
  end

  assign word_done = elem_valid_i && (last_i || cnt_q == CntW'(Lanes - 1));

  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      cnt_q      <= '0;
      mode_q     <= 1'b0;
      pend_q     <= 1'b0;
      overflow_q <= 1'b0;
    end else begin
      pend_q <= word_done;
      if (elem_valid_i) begin
        mode_q <= mode_d;
        cnt_q  <= word_done ? '0 : cnt_q + 1'b1;
      end
      // a finished word that meets a full buffer is lost
      if (pend_q && fifo_full_i) begin
        overflow_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (elem_valid_i) begin
      asm_q <= asm_d;
      if (word_done) begin
        out_q <= {mode_d, asm_d};
      end
    end
  end

  assign push_o     = pend_q && !fifo_full_i;
  assign payload_o  = out_q;
  assign overflow_o = overflow_q;

endmodule : redmule_castin_packer

// File: source/redmule_cast_fifo.sv
// synchronous word buffer between packer and cast unit, payload format set by the instantiator
`timescale 1ns/100ps

module redmule_cast_fifo #(
  parameter int unsigned Depth     = 4,
  parameter type         payload_t = logic [7:0]
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     clear_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     full_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;

  payload_t        mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [PtrW:0]   count_q;
  logic            do_push;
  logic            do_pop;

  assign full_o  = (count_q == (PtrW + 1)'(Depth));
  assign empty_o = (count_q == '0);

  // pushes into a full buffer and pops from an empty one have no effect
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // head word is visible before the pop
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule : redmule_cast_fifo

// File: source/redmule_castin.sv
// consumer side of the cast stage, pops buffered words and widens each lane or passes the word
`timescale 1ns/100ps

module redmule_castin import redmule_cast_pkg::*; #(
  parameter int unsigned Lanes = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   clear_i,
  input  logic                   fifo_empty_i,
  input  logic [Lanes*Fp16W:0]   payload_i,
  input  fp8_fmt_e               src_fmt_i,
  input  logic                   dst_ready_i,
  output logic                   pop_o,
  output logic                   dst_valid_o,
  output logic [Lanes*Fp16W-1:0] dst_o
);

  localparam int unsigned WordW = Lanes * Fp16W;

  logic             cast_mode;
  logic [WordW-1:0] word;
  logic [WordW-1:0] widened;

  // mode bit rides above the word
  assign cast_mode = payload_i[WordW];
  assign word      = payload_i[WordW-1:0];

  assign pop_o = !fifo_empty_i && dst_ready_i;

  // FP8 lanes sit in the low half of the word
  for (genvar i = 0; i < Lanes; i++) begin : gen_lane
    redmule_fp8_widen u_widen (
      .elem_i    ( word[i*Fp8W +: Fp8W]       ),
      .src_fmt_i ( src_fmt_i                  ),
      .elem_o    ( widened[i*Fp16W +: Fp16W]  )
    );
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      dst_valid_o <= 1'b0;
    end else begin
      dst_valid_o <= pop_o;
    end
  end

  // output word holds between strobes, clear leaves it alone
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dst_o <= '0;
    end else if (pop_o) begin
      dst_o <= cast_mode ? widened : word;
    end
  end

endmodule : redmule_castin

// File: source/redmule_castin_top.sv
// top of the input cast stage, connects packer, word buffer and cast unit
`timescale 1ns/100ps

module redmule_castin_top
  import redmule_cast_pkg::*;
  import redmule_stream_pkg::*;
#(
  parameter int unsigned Lanes     = DefaultLanes,
  parameter int unsigned FifoDepth = DefaultFifoDepth
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   elem_valid_i,
  input  logic [Fp16W-1:0]       elem_i,
  input  logic                   last_i,
  input  logic                   cast_i,
  input  fp8_fmt_e               src_fmt_i,
  input  logic                   clear_i,
  input  logic                   dst_ready_i,
  output logic                   dst_valid_o,
  output logic [Lanes*Fp16W-1:0] dst_o,
  output logic                   full_o,
  output logic                   overflow_o
);

  // buffered word, mode bit on top
  typedef struct packed {
    logic                   cast;
    logic [Lanes*Fp16W-1:0] word;
  } payload_t;

  logic     push;
  logic     pop;
  logic     fifo_empty;
  payload_t push_payload;
  payload_t pop_payload;

  redmule_castin_packer #(
    .Lanes ( Lanes )
  ) u_packer (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .clear_i      ( clear_i      ),
    .elem_valid_i ( elem_valid_i ),
    .elem_i       ( elem_i       ),
    .last_i       ( last_i       ),
    .cast_i       ( cast_i       ),
    .fifo_full_i  ( full_o       ),
    .push_o       ( push         ),
    .payload_o    ( push_payload ),
    .overflow_o   ( overflow_o   )
  );

  redmule_cast_fifo #(
    .Depth     ( FifoDepth ),
    .payload_t ( payload_t )
  ) u_fifo (
    .clk_i   ( clk_i        ),
    .rst_i   ( rst_i        ),
    .clear_i ( clear_i      ),
    .push_i  ( push         ),
    .data_i  ( push_payload ),
    .pop_i   ( pop          ),
    .data_o  ( pop_payload  ),
    .empty_o ( fifo_empty   ),
    .full_o  ( full_o       )
  );

  redmule_castin #(
    .Lanes ( Lanes )
  ) u_castin (
    .clk_i        ( clk_i       ),
    .rst_i        ( rst_i       ),
    .clear_i      ( clear_i     ),
    .fifo_empty_i ( fifo_empty  ),
    .payload_i    ( pop_payload ),
    .src_fmt_i    ( src_fmt_i   ),
    .dst_ready_i  ( dst_ready_i ),
    .pop_o        ( pop         ),
    .dst_valid_o  ( dst_valid_o ),
    .dst_o        ( dst_o       )
  );

endmodule : redmule_castin_top

// File: bench/tb_redmule_castin.sv
// self-checking testbench for the cast stage top, runs a word table against a widening model
`timescale 1ns/100ps

module tb_redmule_castin import redmule_cast_pkg::*; ();

  localparam int Lanes     = 4;
  localparam int FifoDepth = 4;
  localparam int Seed      = 16619;
  localparam int Margin    = 100;
  localparam int Period    = 4;
  // strobe edge to the negedge where dst_valid_o is sampled
  localparam int LatNs     = 3 * Period + Period / 2;
  localparam logic [15:0] QNaN = 16'h7e00;

  // one word of stimulus, lane 0 in the low bits of el
  typedef struct packed {
    logic        cast;
    logic        fmt;
    logic [2:0]  n;
    logic [63:0] el;
    logic        stall;
    logic        lat;
  } row_t;

  logic        clk = 1'b0;
  logic        rst_i;
  logic        elem_valid_i;
  logic [15:0] elem_i;
  logic        last_i;
  logic        cast_i;
  fp8_fmt_e    src_fmt_i;
  logic        clear_i;
  logic        dst_ready_i;
  logic        dst_valid_o;
  logic [63:0] dst_o;
  logic        full_o;
  logic        overflow_o;

  row_t        rows[$];
  logic [63:0] exp_q[$];
  int          n_pass = 0;
  int          n_fail = 0;
  int          n_word = 0;
  int          cyc = 0;
  int          limit;
  time         lat_t;
  bit          lat_armed = 1'b0;
  bit          prev_stall = 1'b0;

  redmule_castin_top #(
    .Lanes     ( Lanes     ),
    .FifoDepth ( FifoDepth )
  ) dut0 (
    .clk_i        ( clk          ),
    .rst_i        ( rst_i        ),
    .elem_valid_i ( elem_valid_i ),
    .elem_i       ( elem_i       ),
    .last_i       ( last_i       ),
    .cast_i       ( cast_i       ),
    .src_fmt_i    ( src_fmt_i    ),
    .clear_i      ( clear_i      ),
    .dst_ready_i  ( dst_ready_i  ),
    .dst_valid_o  ( dst_valid_o  ),
    .dst_o        ( dst_o        ),
    .full_o       ( full_o       ),
    .overflow_o   ( overflow_o   )
  );

  always #(Period / 2) clk = ~clk;

  // reference widening, value based
  function automatic logic [15:0] widen_ref(input logic [7:0] b, input logic e4m3);
    logic [3:0] mm;
    int         ue;
    if (!e4m3) begin
      return (b[6:2] == 5'h1f && b[1:0] != 2'b00) ? QNaN : {b, 8'h00};
    end
    if (b[6:3] == 4'hf) begin
      return (b[2:0] == 3'b000) ? {b[7], 15'h7c00} : QNaN;
    end
    if (b[6:0] == 7'h00) begin
      return {b[7], 15'h0000};
    end
    if (b[6:3] != 4'h0) begin
      ue = int'(b[6:3]) - 7;
      mm = {1'b1, b[2:0]};
    end else begin
      // subnormal, shift until the hidden one shows up
      ue = -6;
      mm = {1'b0, b[2:0]};
      while (!mm[3]) begin
        mm = mm << 1;
        ue = ue - 1;
      end
    end
    return {b[7], 5'(ue + 15), mm[2:0], 7'h00};
  endfunction

  function automatic logic [63:0] expect_word(input row_t r);
    logic [63:0] w;
    w = '0;
    for (int i = 0; i < r.n; i++) begin
      w[i*16 +: 16] = r.cast ? widen_ref(r.el[i*16 +: 8], r.fmt) : r.el[i*16 +: 16];
    end
    return w;
  endfunction

  task automatic add_row(input logic cast, input logic fmt, input int n, input logic [63:0] el,
                         input logic stall, input logic lat, input logic rnd);
    row_t r;
    r = '{cast, fmt, 3'(n), el, stall, lat};
    for (int i = 0; i < n; i++) begin
      if (rnd) begin
        r.el[i*16 +: 16] = {8'h00, 8'($urandom())};
      end
    end
    rows.push_back(r);
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0) @(posedge clk);
  endtask

  task automatic drive_row(input row_t r);
    if ((r.stall && !prev_stall) || r.lat || fp8_fmt_e'(r.fmt) != src_fmt_i) begin
      wait_idle();
    end
    // sink stays stalled until the buffer reports full
    if (!r.stall && prev_stall) begin
      while (!full_o) @(posedge clk);
      n_pass++;
      $display("test full_o raised under back-pressure ok");
    end
    prev_stall = r.stall;
    exp_q.push_back(expect_word(r));
    for (int i = 0; i < r.n; i++) begin
      @(posedge clk);
      elem_valid_i <= 1'b1;
      elem_i       <= r.el[i*16 +: 16];
      last_i       <= (i == r.n - 1);
      cast_i       <= r.cast;
      src_fmt_i    <= fp8_fmt_e'(r.fmt);
      dst_ready_i  <= !r.stall;
      if (i == r.n - 1 && r.lat) begin
        lat_t     = $time;
        lat_armed = 1'b1;
      end
    end
    @(posedge clk);
    elem_valid_i <= 1'b0;
    last_i       <= 1'b0;
  endtask

  // one word too many into a full buffer, then flush everything
  task automatic overflow_test();
    wait_idle();
    for (int k = 0; k <= FifoDepth; k++) begin
      @(posedge clk);
      elem_valid_i <= 1'b1;
      elem_i       <= 16'(k + 1);
      last_i       <= 1'b1;
      cast_i       <= 1'b0;
      dst_ready_i  <= 1'b0;
    end
    @(posedge clk);
    elem_valid_i <= 1'b0;
    last_i       <= 1'b0;
    while (!overflow_o) @(posedge clk);
    assert (full_o === 1'b1) else begin
      n_fail++;
      $display("CHECK FAILED: full_o expected %h actual %h", 1'b1, full_o);
    end
    @(posedge clk);
    clear_i <= 1'b1;
    @(posedge clk);
    clear_i     <= 1'b0;
    dst_ready_i <= 1'b1;
    @(posedge clk);
    assert (overflow_o === 1'b0 && full_o === 1'b0) begin
      n_pass++;
      $display("test overflow and clear ok");
    end else begin
      n_fail++;
      $display("CHECK FAILED: overflow_o/full_o expected %h/%h actual %h/%h",
               1'b0, 1'b0, overflow_o, full_o);
    end
    // words dropped by clear must never reach the output
    repeat (4) @(posedge clk);
  endtask

  always @(negedge clk) begin
    logic [63:0] e;
    if (!rst_i && dst_valid_o) begin
      assert (exp_q.size() != 0) else begin
        n_fail++;
        $display("output word %h appeared with no word expected", dst_o);
      end
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        n_word++;
        assert (dst_o === e) begin
          n_pass++;
          $display("test word %0d ok: %h", n_word, dst_o);
        end else begin
          n_fail++;
          $display("CHECK FAILED: dst_o expected %h actual %h (word %0d)", e, dst_o, n_word);
        end
        if (lat_armed) begin
          lat_armed = 1'b0;
          assert ($time - lat_t == LatNs) begin
            n_pass++;
            $display("test latency of word %0d ok", n_word);
          end else begin
            n_fail++;
            $display("word %0d left %0d ns after its last element instead of %0d ns",
                     n_word, $time - lat_t, LatNs);
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc >= limit) begin
      $display("timeout after %0d cycles, the pipeline stopped producing words", limit);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    rst_i        = 1'b1;
    elem_valid_i = 1'b0;
    elem_i       = '0;
    last_i       = 1'b0;
    cast_i       = 1'b0;
    src_fmt_i    = FP8_E5M2;
    clear_i      = 1'b0;
    dst_ready_i  = 1'b1;
    void'($urandom(Seed));

    // E5M2 zeros, largest normals, infinities, NaN payloads, random bytes
    add_row(1, 0, 4, 64'h00fb_007b_0080_0000, 0, 0, 0);
    add_row(1, 0, 4, 64'h00fe_007d_00fc_007c, 0, 0, 0);
    add_row(1, 0, 4, 64'h0083_0001_00ff_007f, 0, 0, 0);
    add_row(1, 0, 4, 64'h0, 0, 0, 1);
    add_row(1, 0, 4, 64'h0, 0, 0, 1);
    // E4M3 every subnormal, then one normal per exponent
    add_row(1, 1, 4, 64'h0004_0003_0002_0001, 0, 0, 0);
    add_row(1, 1, 4, 64'h0087_0007_0006_0005, 0, 0, 0);
    add_row(1, 1, 4, 64'h0020_0018_0010_0008, 0, 0, 0);
    add_row(1, 1, 4, 64'h0040_0038_0030_0028, 0, 0, 0);
    add_row(1, 1, 4, 64'h0060_0058_0050_0048, 0, 0, 0);
    add_row(1, 1, 4, 64'h00bd_00f1_0070_0068, 0, 0, 0);
    add_row(1, 1, 4, 64'h007f_0079_00f8_0078, 0, 0, 0);
    add_row(1, 1, 4, 64'h0, 0, 0, 1);
    // bypass and partial words
    add_row(0, 0, 4, 64'h0001_7bff_c000_3c00, 0, 0, 0);
    add_row(1, 1, 2, 64'h0000_0000_00c0_0038, 0, 0, 0);
    add_row(0, 0, 3, 64'h0000_7e00_abcd_1234, 0, 0, 0);
    add_row(1, 0, 1, 64'h0000_0000_0000_003c, 0, 0, 0);
    // latency from an idle pipeline
    add_row(1, 0, 4, 64'h0044_0033_0022_0011, 0, 1, 0);
    add_row(0, 0, 4, 64'h4444_3333_2222_1111, 0, 1, 0);
    // four stalled words fill the buffer, the next one releases the sink
    add_row(1, 0, 4, 64'h0, 1, 0, 1);
    add_row(1, 0, 4, 64'h0, 1, 0, 1);
    add_row(1, 0, 3, 64'h0, 1, 0, 1);
    add_row(1, 0, 4, 64'h0, 1, 0, 1);
    add_row(1, 0, 4, 64'h0, 0, 0, 1);
    add_row(0, 0, 2, 64'h0, 0, 0, 1);

    limit = 3 + 3 * (FifoDepth + 1) + 12 + Margin;
    foreach (rows[r]) begin
      limit += rows[r].n + 1 + 3 + (rows[r].stall ? FifoDepth : 0);
    end

    repeat (3) @(posedge clk);
    rst_i <= 1'b0;
    foreach (rows[r]) begin
      drive_row(rows[r]);
    end
    overflow_test();
    wait_idle();

    $display("tests passed %0d failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : tb_redmule_castin

// File: redmule_castin.f
source/redmule_cast_pkg.sv
source/redmule_stream_pkg.sv
source/redmule_fp8_widen.sv
source/redmule_castin_packer.sv
source/redmule_cast_fifo.sv
source/redmule_castin.sv
source/redmule_castin_top.sv
bench/tb_redmule_castin.sv

// File: Bender.yml
package:
  name: redmule_castin

sources:
  # packages first, then leaf modules, then the top
  - source/redmule_cast_pkg.sv
  - source/redmule_stream_pkg.sv
  - source/redmule_fp8_widen.sv
  - source/redmule_castin_packer.sv
  - source/redmule_cast_fifo.sv
  - source/redmule_castin.sv
  - source/redmule_castin_top.sv
  - target: test
    files:
      - bench/tb_redmule_castin.sv
